// File: verilog/mc_net_pkg.sv
// network packet field widths and opcode types, imported by every stage that handles packet fields
`default_nettype none

package mc_net_pkg;

  // ------------------------------
  // field widths
  // ------------------------------

  // scratchpad word address as carried on the mesh
  localparam int MC_ADDR_W = 8;
  // payload word
  localparam int MC_DATA_W = 32;
  // one mesh coordinate, x or y
  localparam int MC_CORD_W = 4;

  // ------------------------------
  // opcodes
  // ------------------------------

  // request opcode, one bit on the wire
  typedef enum logic {
    load  = 1'b0,
    store = 1'b1
  } mc_op_e;

  // return opcode, tells the requester which kind of reply this is
  typedef enum logic {
    ret_load  = 1'b0,
    ret_store = 1'b1
  } mc_ret_op_e;

  // ------------------------------
  // packed word widths
  // ------------------------------

  // request word: op, addr, data, src x, src y (msb first)
  localparam int MC_REQ_W = 1 + MC_ADDR_W + MC_DATA_W + 2 * MC_CORD_W;

  // return word: ret op, data, dst x, dst y (msb first)
  localparam int MC_RET_W = 1 + MC_DATA_W + 2 * MC_CORD_W;

endpackage

`default_nettype wire

// File: verilog/mc_cfg_pkg.sv
// default buffer depths, credit counts and scratchpad size, used as top level parameter defaults
`default_nettype none

package mc_cfg_pkg;

  // forward FIFO depth, also the credits the network holds at reset
  localparam int MC_FWD_ELS = 4;

  // response FIFO depth and initial response-space credits
  localparam int MC_REV_ELS = 3;

  // credits for launching local requests onto the mesh
  localparam int MC_LINK_CREDITS = 4;

  // incoming-return FIFO depth
  localparam int MC_RET_ELS = 4;

  // scratchpad words
  localparam int MC_MEM_WORDS = 16;

  // outstanding-request counter width
  localparam int MC_CREDIT_W = 6;

endpackage

`default_nettype wire

// File: verilog/mc_req_if.sv
// request packet bundle with valid and yumi strobes, connects the inner stages of the request path
`timescale 1ns/1ns
`default_nettype none

interface mc_req_if
  import mc_net_pkg::*;
();

  // strobes, yumi means the consumer takes the packet this cycle
  logic                 v;
  logic                 yumi;

  // packet fields
  mc_op_e               op;
  logic [MC_ADDR_W-1:0] addr;
  logic [MC_DATA_W-1:0] data;
  logic [MC_CORD_W-1:0] src_x;
  logic [MC_CORD_W-1:0] src_y;

  // side that offers a request
  modport producer (
    output v, op, addr, data, src_x, src_y,
    input  yumi
  );

  // side that takes a request
  modport consumer (
    input  v, op, addr, data, src_x, src_y,
    output yumi
  );

endinterface

`default_nettype wire

// File: verilog/mc_fifo.sv
// synchronous circular-buffer FIFO, instantiated for the forward, response and incoming-return paths
`timescale 1ns/1ns
`default_nettype none

module mc_fifo #(
  parameter int els_p,
  parameter int width_p
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               wr_v_i,
  input  logic [width_p-1:0] wr_data_i,
  input  logic               rd_yumi_i,
  output logic               rd_v_o,
  output logic [width_p-1:0] rd_data_o,
  output logic               full_o
);

  // pointer width, at least one bit for a single entry
  localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
  // count has to reach els_p itself
  localparam int cnt_w_lp = $clog2(els_p + 1);

  logic [width_p-1:0]  mem_r [els_p];
  logic [ptr_w_lp-1:0] wr_ptr_r;
  logic [ptr_w_lp-1:0] rd_ptr_r;
  logic [cnt_w_lp-1:0] count_r;

  // ------------------------------
  // pointers and occupancy
  // ------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      // wrap at els_p, depth need not be a power of two
      if (wr_v_i) begin
        wr_ptr_r <= (wr_ptr_r == ptr_w_lp'(els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (rd_yumi_i) begin
        rd_ptr_r <= (rd_ptr_r == ptr_w_lp'(els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      // simultaneous write and read leaves the count alone
      count_r <= count_r + cnt_w_lp'(wr_v_i) - cnt_w_lp'(rd_yumi_i);
    end
  end

  // ------------------------------
  // storage
  // ------------------------------

  // write when full is legal only together with a read, so the slot is free
  always_ff @(posedge clk_i) begin
    if (wr_v_i) begin
      mem_r[wr_ptr_r] <= wr_data_i;
    end
  end

  // head entry shows from the cycle after its write
  assign rd_data_o = mem_r[rd_ptr_r];
  assign rd_v_o    = (count_r != '0);
  assign full_o    = (count_r == cnt_w_lp'(els_p));

endmodule

`default_nettype wire

// File: verilog/mc_endpoint_fc.sv
// flow-control stage: gates incoming requests on response space and meters outgoing launches
`timescale 1ns/1ns
`default_nettype none

module mc_endpoint_fc #(
  parameter int rev_els_p,
  parameter int link_credits_p,
  parameter int credit_w_p
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // one pulse per response accepted by the network
  input  logic                  rev_credit_i,
  // outgoing request strobe and link credit returns
  input  logic                  loc_v_i,
  input  logic                  link_credit_i,
  // one pulse per incoming response dequeued by the local side
  input  logic                  loc_ret_done_i,
  output logic                  loc_ready_o,
  output logic [credit_w_p-1:0] out_credits_used_o,
  mc_req_if.consumer            fwd_req,
  mc_req_if.producer            core_req
);

  localparam int rsp_w_lp  = $clog2(rev_els_p + 1);
  localparam int link_w_lp = $clog2(link_credits_p + 1);

  logic [rsp_w_lp-1:0]   rsp_credit_r;
  logic [rsp_w_lp-1:0]   rsp_credit_avail;
  logic                  rsp_has_space;
  logic                  core_take;
  logic [link_w_lp-1:0]  link_credit_r;
  logic                  launch;
  logic [credit_w_p-1:0] out_used_r;

  // ------------------------------
  // incoming request path
  // ------------------------------

  // a credit coming back this cycle already counts, so the slot
  // freed by the network can be reused without a bubble
  assign rsp_credit_avail = rsp_credit_r + rsp_w_lp'(rev_credit_i);
  assign rsp_has_space    = (rsp_credit_avail != '0);

  // offer to the client only when its reply is sure of a response FIFO slot
  assign core_req.v     = fwd_req.v & rsp_has_space;
  assign core_req.op    = fwd_req.op;
  assign core_req.addr  = fwd_req.addr;
  assign core_req.data  = fwd_req.data;
  assign core_req.src_x = fwd_req.src_x;
  assign core_req.src_y = fwd_req.src_y;

  // client yumi is the forward FIFO dequeue
  assign fwd_req.yumi = core_req.yumi;
  assign core_take    = core_req.v & core_req.yumi;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_credit_r <= rsp_w_lp'(rev_els_p);
    end else begin
      rsp_credit_r <= rsp_credit_avail - rsp_w_lp'(core_take);
    end
  end

  // ------------------------------
  // outgoing request path
  // ------------------------------

  // link credits start full, launches spend them
  assign loc_ready_o = (link_credit_r != '0);
  assign launch      = loc_v_i & loc_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      link_credit_r <= link_w_lp'(link_credits_p);
    end else begin
      link_credit_r <= link_credit_r + link_w_lp'(link_credit_i) - link_w_lp'(launch);
    end
  end

  // ------------------------------
  // outstanding requests
  // ------------------------------

  // up per launch, down per response handed to the local side
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      out_used_r <= '0;
    end else begin
      out_used_r <= out_used_r + credit_w_p'(launch) - credit_w_p'(loc_ret_done_i);
    end
  end

  assign out_credits_used_o = out_used_r;

endmodule

`default_nettype wire

// File: verilog/mc_mem_client.sv
// scratchpad client: services loads and stores and registers one return word per request
`timescale 1ns/1ns
`default_nettype none

module mc_mem_client
  import mc_net_pkg::*;
#(
  parameter int mem_words_p
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  mc_req_if.consumer           core_req,
  // write side of the response FIFO
  output logic                 ret_wr_v_o,
  output mc_ret_op_e           ret_op_o,
  output logic [MC_DATA_W-1:0] ret_data_o,
  output logic [MC_CORD_W-1:0] ret_dst_x_o,
  output logic [MC_CORD_W-1:0] ret_dst_y_o
);

  localparam int idx_w_lp = (mem_words_p > 1) ? $clog2(mem_words_p) : 1;

  logic [MC_DATA_W-1:0] mem_r [mem_words_p];
  logic [idx_w_lp-1:0]  idx;
  logic                 is_store;
  logic                 ret_wr_v_r;
  mc_ret_op_e           ret_op_r;
  logic [MC_DATA_W-1:0] ret_data_r;
  logic [MC_CORD_W-1:0] ret_dst_x_r;
  logic [MC_CORD_W-1:0] ret_dst_y_r;

  // addresses beyond the scratchpad alias back into it
  assign idx      = idx_w_lp'(core_req.addr % mem_words_p);
  assign is_store = (core_req.op == store);

  // response space is already checked upstream, take whatever is offered
  assign core_req.yumi = core_req.v;

  // ------------------------------
  // scratchpad and reply strobe
  // ------------------------------

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ret_wr_v_r <= 1'b0;
      for (int i = 0; i < mem_words_p; i++) begin
        mem_r[i] <= '0;
      end
    end else begin
      ret_wr_v_r <= core_req.v;
      if (core_req.v && is_store) begin
        mem_r[idx] <= core_req.data;
      end
    end
  end

  // ------------------------------
  // reply payload
  // ------------------------------

  // load reads the old word in the accept cycle, a store right before
  // it has already landed at the previous edge
  always_ff @(posedge clk_i) begin
    if (core_req.v) begin
      ret_op_r    <= is_store ? ret_store : ret_load;
      ret_data_r  <= is_store ? '0 : mem_r[idx];
      // reply goes back to whoever sent the request
      ret_dst_x_r <= core_req.src_x;
      ret_dst_y_r <= core_req.src_y;
    end
  end

  assign ret_wr_v_o  = ret_wr_v_r;
  assign ret_op_o    = ret_op_r;
  assign ret_data_o  = ret_data_r;
  assign ret_dst_x_o = ret_dst_x_r;
  assign ret_dst_y_o = ret_dst_y_r;

endmodule

`default_nettype wire

// File: verilog/mc_endpoint_top.sv
// mesh endpoint top level: wires the three FIFOs, flow control and scratchpad client to the ports
`timescale 1ns/1ns
`default_nettype none

module mc_endpoint_top
  import mc_net_pkg::*, mc_cfg_pkg::*;
#(
  parameter int fwd_els_p      = MC_FWD_ELS,
  parameter int rev_els_p      = MC_REV_ELS,
  parameter int link_credits_p = MC_LINK_CREDITS,
  parameter int ret_els_p      = MC_RET_ELS,
  parameter int mem_words_p    = MC_MEM_WORDS,
  parameter int credit_w_p     = MC_CREDIT_W
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // incoming requests from the mesh
  input  logic                  req_v_i,
  input  mc_op_e                req_op_i,
  input  logic [MC_ADDR_W-1:0]  req_addr_i,
  input  logic [MC_DATA_W-1:0]  req_data_i,
  input  logic [MC_CORD_W-1:0]  req_src_x_i,
  input  logic [MC_CORD_W-1:0]  req_src_y_i,
  output logic                  req_credit_o,
  // responses to the mesh
  output logic                  ret_v_o,
  output mc_ret_op_e            ret_op_o,
  output logic [MC_DATA_W-1:0]  ret_data_o,
  output logic [MC_CORD_W-1:0]  ret_dst_x_o,
  output logic [MC_CORD_W-1:0]  ret_dst_y_o,
  input  logic                  ret_ready_i,
  // outgoing requests from the tile
  input  logic                  loc_v_i,
  input  mc_op_e                loc_op_i,
  input  logic [MC_ADDR_W-1:0]  loc_addr_i,
  input  logic [MC_DATA_W-1:0]  loc_data_i,
  input  logic [MC_CORD_W-1:0]  loc_dst_x_i,
  input  logic [MC_CORD_W-1:0]  loc_dst_y_i,
  output logic                  loc_ready_o,
  output logic                  net_req_v_o,
  output mc_op_e                net_req_op_o,
  output logic [MC_ADDR_W-1:0]  net_req_addr_o,
  output logic [MC_DATA_W-1:0]  net_req_data_o,
  output logic [MC_CORD_W-1:0]  net_req_dst_x_o,
  output logic [MC_CORD_W-1:0]  net_req_dst_y_o,
  input  logic                  net_req_credit_i,
  // incoming responses for the tile
  input  logic                  net_ret_v_i,
  input  logic [MC_DATA_W-1:0]  net_ret_data_i,
  input  logic                  loc_ret_yumi_i,
  output logic                  loc_ret_v_o,
  output logic [MC_DATA_W-1:0]  loc_ret_data_o,
  output logic                  loc_ret_full_o,
  output logic [credit_w_p-1:0] out_credits_used_o
);

  logic [MC_REQ_W-1:0]  fwd_data_lo;
  logic                 rsp_wr_v;
  mc_ret_op_e           rsp_op;
  logic [MC_DATA_W-1:0] rsp_data;
  logic [MC_CORD_W-1:0] rsp_dst_x;
  logic [MC_CORD_W-1:0] rsp_dst_y;
  logic [MC_RET_W-1:0]  rsp_data_lo;
  logic                 rsp_accept;

  mc_req_if fwd_req ();
  mc_req_if core_req ();

  // ------------------------------
  // incoming request path
  // ------------------------------

  // the network holds fwd_els_p credits, so this FIFO never overflows
  mc_fifo #(.els_p(fwd_els_p), .width_p(MC_REQ_W)) fwd_fifo (
    .clk_i, .reset_i,
    .wr_v_i    (req_v_i),
    .wr_data_i ({req_op_i, req_addr_i, req_data_i, req_src_x_i, req_src_y_i}),
    .rd_yumi_i (fwd_req.yumi),
    .rd_v_o    (fwd_req.v),
    .rd_data_o (fwd_data_lo),
    .full_o    ()
  );

  // unpack the head word onto the request bundle
  assign fwd_req.op    = mc_op_e'(fwd_data_lo[MC_REQ_W-1]);
  assign fwd_req.addr  = fwd_data_lo[MC_REQ_W-2 -: MC_ADDR_W];
  assign fwd_req.data  = fwd_data_lo[2*MC_CORD_W +: MC_DATA_W];
  assign fwd_req.src_x = fwd_data_lo[MC_CORD_W +: MC_CORD_W];
  assign fwd_req.src_y = fwd_data_lo[0 +: MC_CORD_W];

  // each dequeue hands one link credit back to the network
  assign req_credit_o = fwd_req.yumi;

  mc_endpoint_fc #(
    .rev_els_p(rev_els_p), .link_credits_p(link_credits_p), .credit_w_p(credit_w_p)
  ) fc (
    .clk_i, .reset_i,
    .rev_credit_i       (rsp_accept),
    .loc_v_i            (loc_v_i),
    .link_credit_i      (net_req_credit_i),
    .loc_ret_done_i     (loc_ret_v_o & loc_ret_yumi_i),
    .loc_ready_o        (loc_ready_o),
    .out_credits_used_o (out_credits_used_o),
    .fwd_req            (fwd_req.consumer),
    .core_req           (core_req.producer)
  );

  mc_mem_client #(.mem_words_p(mem_words_p)) client (
    .clk_i, .reset_i,
    .core_req    (core_req.consumer),
    .ret_wr_v_o  (rsp_wr_v),
    .ret_op_o    (rsp_op),
    .ret_data_o  (rsp_data),
    .ret_dst_x_o (rsp_dst_x),
    .ret_dst_y_o (rsp_dst_y)
  );

  // ------------------------------
  // response path
  // ------------------------------

  mc_fifo #(.els_p(rev_els_p), .width_p(MC_RET_W)) rsp_fifo (
    .clk_i, .reset_i,
    .wr_v_i    (rsp_wr_v),
    .wr_data_i ({rsp_op, rsp_data, rsp_dst_x, rsp_dst_y}),
    .rd_yumi_i (rsp_accept),
    .rd_v_o    (ret_v_o),
    .rd_data_o (rsp_data_lo),
    .full_o    ()
  );

  // an accepted response frees one slot, that is the response-space credit
  assign rsp_accept  = ret_v_o & ret_ready_i;
  assign ret_op_o    = mc_ret_op_e'(rsp_data_lo[MC_RET_W-1]);
  assign ret_data_o  = rsp_data_lo[2*MC_CORD_W +: MC_DATA_W];
  assign ret_dst_x_o = rsp_data_lo[MC_CORD_W +: MC_CORD_W];
  assign ret_dst_y_o = rsp_data_lo[0 +: MC_CORD_W];

  // ------------------------------
  // outgoing requests and returns
  // ------------------------------

  // launch goes straight onto the mesh in the same cycle
  assign net_req_v_o     = loc_v_i & loc_ready_o;
  assign net_req_op_o    = loc_op_i;
  assign net_req_addr_o  = loc_addr_i;
  assign net_req_data_o  = loc_data_i;
  assign net_req_dst_x_o = loc_dst_x_i;
  assign net_req_dst_y_o = loc_dst_y_i;

  // sized for the outstanding limit, the mesh never overruns it
  mc_fifo #(.els_p(ret_els_p), .width_p(MC_DATA_W)) loc_ret_fifo (
    .clk_i, .reset_i,
    .wr_v_i    (net_ret_v_i),
    .wr_data_i (net_ret_data_i),
    .rd_yumi_i (loc_ret_yumi_i),
    .rd_v_o    (loc_ret_v_o),
    .rd_data_o (loc_ret_data_o),
    .full_o    (loc_ret_full_o)
  );

endmodule

`default_nettype wire

// File: verif/mc_endpoint_chk.sv
// concurrent checks on credits, response ordering and reset values, bound into the endpoint top
`timescale 1ns/1ns
`default_nettype none

module mc_endpoint_chk
  import mc_net_pkg::*;
#(
  parameter int rev_els_p,
  parameter int credit_w_p
) (
  input logic                  clk_i,
  input logic                  reset_i,
  input logic                  req_credit_i,
  input logic                  rsp_v_i,
  input logic                  rsp_ready_i,
  input logic [MC_DATA_W-1:0]  rsp_data_i,
  input logic                  loc_ready_i,
  input logic                  net_req_v_i,
  input logic                  net_ret_v_i,
  input logic                  loc_ret_v_i,
  input logic                  loc_ret_yumi_i,
  input logic                  loc_ret_full_i,
  input logic [credit_w_p-1:0] out_used_i
);

  // count of failed assertions, read by the testbench
  int fail_cnt = 0;
  // requests dequeued whose response is not yet accepted
  int pend_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_r <= 0;
    end else begin
      pend_r <= pend_r + int'(req_credit_i) - int'(rsp_v_i & rsp_ready_i);
    end
  end

  // ------------------------------
  // reset values
  // ------------------------------

  a_reset_vals: assert property (@(posedge clk_i) $fell(reset_i) |->
    !rsp_v_i && !loc_ret_v_i && !net_req_v_i && !req_credit_i && out_used_i == '0 && loc_ready_i)
    else begin $error("outputs not at reset values when reset falls"); fail_cnt++; end

  // ------------------------------
  // credits and ordering
  // ------------------------------

  // never more replies in flight than response FIFO slots
  a_rsp_space: assert property (@(posedge clk_i) disable iff (reset_i) pend_r <= rev_els_p)
    else begin $error("more requests taken than response space"); fail_cnt++; end

  // a held response keeps its word
  a_rsp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_v_i && !rsp_ready_i |=> rsp_v_i && $stable(rsp_data_i))
    else begin $error("response changed under back-pressure"); fail_cnt++; end

  a_ret_full: assert property (@(posedge clk_i) disable iff (reset_i)
    loc_ret_full_i && net_ret_v_i |-> loc_ret_yumi_i)
    else begin $error("incoming-return FIFO written while full"); fail_cnt++; end

  a_ret_yumi: assert property (@(posedge clk_i) disable iff (reset_i) loc_ret_yumi_i |-> loc_ret_v_i)
    else begin $error("incoming return dequeued while empty"); fail_cnt++; end

endmodule

bind mc_endpoint_top mc_endpoint_chk #(.rev_els_p(rev_els_p), .credit_w_p(credit_w_p)) chk (
  .clk_i, .reset_i,
  .req_credit_i (req_credit_o),
  .rsp_v_i (ret_v_o), .rsp_ready_i (ret_ready_i), .rsp_data_i (ret_data_o),
  .loc_ready_i (loc_ready_o),
  .net_req_v_i (net_req_v_o),
  .net_ret_v_i, .loc_ret_v_i (loc_ret_v_o), .loc_ret_yumi_i, .loc_ret_full_i (loc_ret_full_o),
  .out_used_i (out_credits_used_o)
);

`default_nettype wire

// File: verif/mc_endpoint_tb.sv
// endpoint testbench: plays the mesh and the local tile, checks responses and credits by assertion
`timescale 1ns/1ns
`default_nettype none

module mc_endpoint_tb
  import mc_net_pkg::*, mc_cfg_pkg::*;
();

  localparam int clk_period_lp  = 100;
  localparam int n_req_lp       = 200;
  localparam int n_loc_lp       = 100;
  // cycles allowed per transaction, back-pressure included
  localparam int cyc_per_txn_lp = 20;

  logic clk_i = 1'b0;
  logic reset_i, req_v_i, ret_ready_i, loc_v_i, net_req_credit_i, net_ret_v_i, loc_ret_yumi_i;
  mc_op_e req_op_i, loc_op_i, net_req_op_o;
  logic [MC_ADDR_W-1:0] req_addr_i, loc_addr_i, net_req_addr_o;
  logic [MC_DATA_W-1:0] req_data_i, loc_data_i, net_ret_data_i;
  logic [MC_DATA_W-1:0] ret_data_o, net_req_data_o, loc_ret_data_o;
  logic [MC_CORD_W-1:0] req_src_x_i, req_src_y_i, loc_dst_x_i, loc_dst_y_i;
  logic [MC_CORD_W-1:0] ret_dst_x_o, ret_dst_y_o, net_req_dst_x_o, net_req_dst_y_o;
  logic req_credit_o, ret_v_o, loc_ready_o, net_req_v_o, loc_ret_v_o, loc_ret_full_o;
  mc_ret_op_e ret_op_o;
  logic [MC_CREDIT_W-1:0] out_credits_used_o;

  // ------------------------------
  // reference state
  // ------------------------------

  integer seed = 32'h3035;
  logic [MC_DATA_W-1:0] mem_model [MC_MEM_WORDS];
  // expected replies in request order
  logic [MC_RET_W-1:0]  exp_rsp_q [$];
  // replies the mesh still owes, and those sitting in the DUT
  logic [MC_DATA_W-1:0] owed_ret_q [$];
  logic [MC_DATA_W-1:0] held_ret_q [$];
  // cycle at which each link credit goes back
  int credit_due_q [$];
  int cyc, fwd_credits, link_cnt, out_cnt, n_sent, n_deq, n_acc, n_launch, n_loc_done;

  mc_endpoint_top mc_endpoint_top_i (.*);

  always #(clk_period_lp / 2) clk_i = ~clk_i;

  function automatic string format_failure(input string what);
    return $sformatf("FAILED at %0t: %s", $time, what);
  endfunction

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  // ------------------------------
  // stimulus, falling edge
  // ------------------------------

  task automatic drive_inputs();
    int idx;
    req_v_i = 1'b0;
    if (n_sent < n_req_lp && fwd_credits > 0 && {$random(seed)} % 3 != 0) begin
      req_v_i     = 1'b1;
      // early traffic is all stores so later loads see data
      req_op_i    = (n_sent < 32 || {$random(seed)} % 2 == 0) ? store : load;
      req_addr_i  = MC_ADDR_W'({$random(seed)} % 32);
      req_data_i  = $random(seed);
      req_src_x_i = MC_CORD_W'($random(seed));
      req_src_y_i = MC_CORD_W'($random(seed));
      idx = req_addr_i % MC_MEM_WORDS;
      if (req_op_i == store) begin
        mem_model[idx] = req_data_i;
        exp_rsp_q.push_back({ret_store, MC_DATA_W'(0), req_src_x_i, req_src_y_i});
      end else begin
        exp_rsp_q.push_back({ret_load, mem_model[idx], req_src_x_i, req_src_y_i});
      end
      fwd_credits--;
      n_sent++;
    end
    // alternating long stretches of back-pressure
    ret_ready_i = ((cyc / 40) % 2 == 1) && ({$random(seed)} % 4 != 0);
    loc_v_i = 1'b0;
    if (n_launch < n_loc_lp && out_cnt < MC_RET_ELS && {$random(seed)} % 2 == 0) begin
      loc_v_i     = 1'b1;
      loc_op_i    = ({$random(seed)} % 2 == 0) ? store : load;
      loc_addr_i  = MC_ADDR_W'($random(seed));
      loc_data_i  = $random(seed);
      loc_dst_x_i = MC_CORD_W'($random(seed));
      loc_dst_y_i = MC_CORD_W'($random(seed));
    end
    net_req_credit_i = (credit_due_q.size() != 0 && credit_due_q[0] <= cyc);
    if (net_req_credit_i) void'(credit_due_q.pop_front());
    net_ret_v_i = 1'b0;
    if (owed_ret_q.size() != 0 && {$random(seed)} % 2 == 0) begin
      net_ret_v_i    = 1'b1;
      net_ret_data_i = owed_ret_q.pop_front();
    end
    loc_ret_yumi_i = loc_ret_v_o && ({$random(seed)} % 3 != 0);
  endtask

  // ------------------------------
  // checks, mid low phase
  // ------------------------------

  task automatic sample_outputs();
    logic launch;
    // a launch needs a link credit held by the endpoint
    launch = loc_v_i && (link_cnt != 0);
    assert (loc_ready_o == (link_cnt != 0))
      else stop_with_error(format_failure("loc_ready_o does not follow link credits"));
    assert (net_req_v_o == launch && (!net_req_v_o || link_cnt != 0))
      else stop_with_error(format_failure("net_req_v_o without a link credit"));
    assert (!net_req_v_o || {net_req_op_o, net_req_addr_o, net_req_data_o, net_req_dst_x_o,
            net_req_dst_y_o} == {loc_op_i, loc_addr_i, loc_data_i, loc_dst_x_i, loc_dst_y_i})
      else stop_with_error(format_failure("net_req fields differ from loc fields"));
    assert (out_credits_used_o == MC_CREDIT_W'(out_cnt))
      else stop_with_error(format_failure("out_credits_used_o is wrong"));
    assert (loc_ret_v_o == (held_ret_q.size() != 0))
      else stop_with_error(format_failure("loc_ret_v_o is wrong"));
    assert (loc_ret_full_o == (held_ret_q.size() == MC_RET_ELS))
      else stop_with_error(format_failure("loc_ret_full_o is wrong"));
    if (loc_ret_yumi_i) begin
      assert (loc_ret_data_o == held_ret_q[0])
        else stop_with_error(format_failure("incoming response out of order"));
      void'(held_ret_q.pop_front());
      n_loc_done++;
    end
    if (net_ret_v_i) held_ret_q.push_back(net_ret_data_i);
    if (launch) begin
      link_cnt--;
      n_launch++;
      // credits can outlive the round trip, so link credits run dry now and then
      credit_due_q.push_back(cyc + 1 + {$random(seed)} % 8);
      owed_ret_q.push_back($random(seed));
    end
    if (net_req_credit_i) link_cnt++;
    out_cnt = out_cnt + int'(launch) - int'(loc_ret_yumi_i);
    if (req_credit_o) begin
      fwd_credits++;
      n_deq++;
    end
    if (ret_v_o && ret_ready_i) begin
      assert (exp_rsp_q.size() != 0 &&
              {ret_op_o, ret_data_o, ret_dst_x_o, ret_dst_y_o} == exp_rsp_q[0])
        else stop_with_error(format_failure("response does not match the expected one"));
      void'(exp_rsp_q.pop_front());
      n_acc++;
    end
    assert (n_deq - n_acc <= MC_REV_ELS)
      else stop_with_error(format_failure("too many requests taken under back-pressure"));
  endtask

  initial begin
    {reset_i, req_v_i, ret_ready_i, loc_v_i, net_req_credit_i, net_ret_v_i, loc_ret_yumi_i} = 7'h40;
    req_op_i = load;
    loc_op_i = load;
    {req_addr_i, loc_addr_i, req_data_i, loc_data_i, net_ret_data_i} = '0;
    {req_src_x_i, req_src_y_i, loc_dst_x_i, loc_dst_y_i} = '0;
    foreach (mem_model[i]) mem_model[i] = '0;
    {cyc, out_cnt, n_sent, n_deq, n_acc, n_launch, n_loc_done} = '0;
    fwd_credits = MC_FWD_ELS;
    link_cnt    = MC_LINK_CREDITS;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    while (n_acc < n_req_lp || n_loc_done < n_loc_lp) begin
      @(negedge clk_i);
      cyc++;
      drive_inputs();
      #10;
      sample_outputs();
      if (mc_endpoint_top_i.chk.fail_cnt != 0) stop_with_error("a checker assertion failed");
    end
    assert (n_deq == n_req_lp && exp_rsp_q.size() == 0 && out_cnt == 0)
      else stop_with_error(format_failure("requests and responses do not balance"));
    if (mc_endpoint_top_i.chk.fail_cnt != 0) begin
      stop_with_error("a checker assertion failed");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

  // watchdog
  initial begin
    #(clk_period_lp * (n_req_lp + n_loc_lp + 8) * cyc_per_txn_lp);
    stop_with_error("timeout: transactions did not complete in time");
  end

endmodule

`default_nettype wire

// File: mc_endpoint_top.f
verilog/mc_net_pkg.sv
verilog/mc_cfg_pkg.sv
verilog/mc_req_if.sv
verilog/mc_fifo.sv
verilog/mc_endpoint_fc.sv
verilog/mc_mem_client.sv
verilog/mc_endpoint_top.sv
verif/mc_endpoint_chk.sv
verif/mc_endpoint_tb.sv

// File: Makefile
SIM := obj_dir/Vmc_endpoint_tb

# rebuilt only when a source or the file list changes
$(SIM): mc_endpoint_top.f $(wildcard verilog/*.sv) $(wildcard verif/*.sv)
	verilator --binary --assert -Wno-fatal --top-module mc_endpoint_tb -f mc_endpoint_top.f

.PHONY: run clean

# the run passes only if the pass message shows up in the output
run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+100)"; echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
